//--- rtl/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath word and register width
`define CPU_WORD_BITS 16

// Architectural registers, r0 reads as zero
`define CPU_REG_COUNT 16

// Word address bits of the unified memory
`define CPU_MEM_ADDR_BITS 12

// First fetch address out of reset
`define CPU_RESET_PC 0

`endif

//--- rtl/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

	typedef logic [`CPU_WORD_BITS-1:0] word_t;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

	// Unlisted codes fall through as no-ops
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_XOR  = 4'h2,
		OP_AND  = 4'h3,
		OP_ADDI = 4'h4,
		OP_LW   = 4'h8,
		OP_SW   = 4'h9,
		OP_LLB  = 4'hA,
		OP_B    = 4'hC,
		OP_HLT  = 4'hF
	} opcode_t;

	typedef enum logic [2:0] {
		COND_NE = 3'b000,
		COND_EQ = 3'b001,
		COND_GT = 3'b010,
		COND_LT = 3'b011,
		COND_GE = 3'b100,
		COND_LE = 3'b101,
		COND_OV = 3'b110,
		COND_AL = 3'b111
	} cond_t;

	typedef struct packed {
		logic n;
		logic z;
		logic v;
	} flags_t;

	// Same word, three decode layouts
	typedef union packed {
		struct packed {opcode_t opcode; reg_idx_t rd; reg_idx_t rs; reg_idx_t rt;} r_form;
		struct packed {opcode_t opcode; reg_idx_t rd; logic [7:0] imm8;} byte_form;
		struct packed {opcode_t opcode; cond_t cond; logic [8:0] off9;} branch_form;
	} instr_t;

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_stage
	import cpu_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   stall,
	input  logic   branch_taken,
	input  word_t  branch_target,
	input  logic   halt_seen,
	input  logic   fetch_gnt,
	input  word_t  mem_rdata,
	output logic   fetch_req,
	output word_t  fetch_addr,
	output word_t  pc,
	output instr_t instr,
	output word_t  pc_plus2,
	output logic   f_valid
);
	logic  halted;
	word_t pc_seq;

	assign pc_seq = pc + word_t'(2);
	// Always fetch the word at the PC
	assign fetch_addr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= word_t'(`CPU_RESET_PC);
			halted <= 1'b0;
			fetch_req <= 1'b0;
			f_valid <= 1'b0;
		end else begin
			// Sticky once HLT reaches decode
			halted <= halted | halt_seen;
			fetch_req <= !(halted || halt_seen);
			if (!stall) begin
				if (branch_taken) begin
					// Wrong-path word becomes a bubble
					pc <= branch_target;
					f_valid <= 1'b0;
				end else if (halt_seen) begin
					f_valid <= 1'b0;
				end else if (fetch_gnt) begin
					pc <= pc_seq;
					f_valid <= 1'b1;
				end else begin
					// Lost arbitration, retry same PC
					f_valid <= 1'b0;
				end
			end
		end
		// Payload only, qualified by f_valid
		if (!stall && fetch_gnt) begin
			instr <= mem_rdata;
			pc_plus2 <= pc_seq;
		end
	end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_stage
	import cpu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     stall,
	input  instr_t   instr,
	input  word_t    pc_plus2,
	input  logic     f_valid,
	input  flags_t   flags,
	input  word_t    reg_rs_data,
	input  word_t    reg_rt_data,
	output reg_idx_t rs,
	output reg_idx_t rt,
	output logic     uses_rs,
	output logic     uses_rt,
	output logic     branch_taken,
	output word_t    branch_target,
	output logic     halt_seen,
	output logic     d_valid,
	output opcode_t  d_op,
	output reg_idx_t d_rd,
	output word_t    d_a,
	output word_t    d_b,
	output word_t    d_store_data,
	output logic     d_reg_write,
	output logic     d_halt
);
	opcode_t op;
	word_t   imm4_ext;
	word_t   mem_off;
	word_t   imm8_ext;
	word_t   br_off;
	word_t   operand_b;
	logic    writes_reg;
	logic    cond_true;

	assign op = instr.r_form.opcode;
	assign rs = instr.r_form.rs;
	// SW keeps its data register in bits 11-8
	assign rt = (op == OP_SW) ? instr.r_form.rd : instr.r_form.rt;

	// Immediates
	assign imm4_ext = {{(`CPU_WORD_BITS-4){instr.r_form.rt[3]}}, instr.r_form.rt};
	// Word offset, scaled to bytes
	assign mem_off = {{(`CPU_WORD_BITS-5){instr.r_form.rt[3]}}, instr.r_form.rt, 1'b0};
	assign imm8_ext = {{(`CPU_WORD_BITS-8){1'b0}}, instr.byte_form.imm8};
	assign br_off = {{(`CPU_WORD_BITS-10){instr.branch_form.off9[8]}},
		instr.branch_form.off9, 1'b0};

	// Source usage and B operand select
	always_comb begin
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		writes_reg = 1'b0;
		operand_b = reg_rt_data;
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				writes_reg = 1'b1;
			end
			OP_ADDI: begin
				uses_rs = 1'b1;
				writes_reg = 1'b1;
				operand_b = imm4_ext;
			end
			OP_LLB: begin
				writes_reg = 1'b1;
				operand_b = imm8_ext;
			end
			OP_LW: begin
				uses_rs = 1'b1;
				writes_reg = 1'b1;
				operand_b = mem_off;
			end
			OP_SW: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				operand_b = mem_off;
			end
			default: begin
				operand_b = reg_rt_data;
			end
		endcase
	end

	// Branch condition against the NZV register
	always_comb begin
		cond_true = 1'b1;
		case (instr.branch_form.cond)
			COND_NE: cond_true = !flags.z;
			COND_EQ: cond_true = flags.z;
			COND_GT: cond_true = !flags.z && !flags.n;
			COND_LT: cond_true = flags.n;
			COND_GE: cond_true = !flags.n;
			COND_LE: cond_true = flags.n || flags.z;
			COND_OV: cond_true = flags.v;
			COND_AL: cond_true = 1'b1;
		endcase
	end

	// Stall holds off both redirect and halt
	assign branch_taken = f_valid && !stall && (op == OP_B) && cond_true;
	assign branch_target = pc_plus2 + br_off;
	assign halt_seen = f_valid && !stall && (op == OP_HLT);

	// Decode/execute register
	always_ff @(posedge clk) begin
		if (rst)
			d_valid <= 1'b0;
		else
			d_valid <= f_valid && !stall;
		d_op <= op;
		d_rd <= instr.byte_form.rd;
		d_a <= reg_rs_data;
		d_b <= operand_b;
		d_store_data <= reg_rt_data;
		d_reg_write <= writes_reg;
		d_halt <= (op == OP_HLT);
	end

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_file
	import cpu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  reg_idx_t rs,
	input  reg_idx_t rt,
	input  logic     wb_en,
	input  reg_idx_t wb_rd,
	input  word_t    wb_data,
	output word_t    rs_data,
	output word_t    rt_data
);
	word_t regs [`CPU_REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_rd != '0) begin
			// r0 writes dropped
			regs[wb_rd] <= wb_data;
		end
	end

	// Same-cycle writeback visible to decode
	assign rs_data = (rs == '0) ? '0 : (wb_en && wb_rd == rs) ? wb_data : regs[rs];
	assign rt_data = (rt == '0) ? '0 : (wb_en && wb_rd == rt) ? wb_data : regs[rt];

endmodule

//--- rtl/detection_unit.sv
`timescale 1ns/1ps

module detection_unit
	import cpu_pkg::*;
(
	input  reg_idx_t rs,
	input  reg_idx_t rt,
	input  logic     uses_rs,
	input  logic     uses_rt,
	input  logic     f_valid,
	input  logic     f_is_branch,
	input  logic     d_valid,
	input  reg_idx_t d_rd,
	input  logic     d_reg_write,
	input  logic     d_sets_flags,
	input  logic     e_valid,
	input  reg_idx_t e_rd,
	input  logic     e_reg_write,
	output logic     stall
);
	logic d_writes;
	logic e_writes;
	logic rs_hit;
	logic rt_hit;
	logic flag_hit;

	// Pending writes in execute and memory
	assign d_writes = d_valid && d_reg_write;
	assign e_writes = e_valid && e_reg_write;

	// r0 is never pending
	assign rs_hit = uses_rs && (rs != '0) &&
		((d_writes && d_rd == rs) || (e_writes && e_rd == rs));
	assign rt_hit = uses_rt && (rt != '0) &&
		((d_writes && d_rd == rt) || (e_writes && e_rd == rt));
	// Flags land when the setter leaves execute
	assign flag_hit = f_is_branch && d_valid && d_sets_flags;

	assign stall = f_valid && (rs_hit || rt_hit || flag_hit);

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_stage
	import cpu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     d_valid,
	input  opcode_t  d_op,
	input  reg_idx_t d_rd,
	input  word_t    d_a,
	input  word_t    d_b,
	input  word_t    d_store_data,
	input  logic     d_reg_write,
	input  logic     d_halt,
	output flags_t   flags,
	output logic     d_sets_flags,
	output logic     e_valid,
	output opcode_t  e_op,
	output reg_idx_t e_rd,
	output word_t    e_result,
	output word_t    e_store_data,
	output logic     e_reg_write,
	output logic     e_halt
);
	localparam int MSB = `CPU_WORD_BITS - 1;

	word_t sum;
	word_t diff;
	word_t result;
	logic  add_ovf;
	logic  sub_ovf;
	logic  arith;

	assign sum = d_a + d_b;
	assign diff = d_a - d_b;
	// Signed overflow from operand and result signs
	assign add_ovf = (d_a[MSB] == d_b[MSB]) && (sum[MSB] != d_a[MSB]);
	assign sub_ovf = (d_a[MSB] != d_b[MSB]) && (diff[MSB] != d_a[MSB]);

	assign arith = (d_op == OP_ADD) || (d_op == OP_SUB) || (d_op == OP_ADDI);
	assign d_sets_flags = arith || (d_op == OP_AND) || (d_op == OP_XOR);

	always_comb begin
		case (d_op)
			// Address add shares the adder
			OP_ADD, OP_ADDI, OP_LW, OP_SW: result = sum;
			OP_SUB: result = diff;
			OP_AND: result = d_a & d_b;
			OP_XOR: result = d_a ^ d_b;
			// LLB passes the immediate
			OP_LLB: result = d_b;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
			e_valid <= 1'b0;
		end else begin
			e_valid <= d_valid;
			if (d_valid && d_sets_flags) begin
				flags.n <= result[MSB];
				flags.z <= (result == '0);
				// Logic ops clear V
				flags.v <= arith && ((d_op == OP_SUB) ? sub_ovf : add_ovf);
			end
		end
		e_op <= d_op;
		e_rd <= d_rd;
		e_result <= result;
		e_store_data <= d_store_data;
		e_reg_write <= d_reg_write;
		e_halt <= d_halt;
	end

endmodule

//--- rtl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage
	import cpu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     e_valid,
	input  opcode_t  e_op,
	input  reg_idx_t e_rd,
	input  word_t    e_result,
	input  word_t    e_store_data,
	input  logic     e_reg_write,
	input  logic     e_halt,
	input  word_t    mem_rdata,
	output logic     data_req,
	output word_t    data_addr,
	output logic     data_we,
	output word_t    data_wdata,
	output logic     wb_en,
	output reg_idx_t wb_rd,
	output word_t    wb_data,
	output logic     hlt
);
	logic is_load;

	assign is_load = (e_op == OP_LW);

	// Outranks fetch, so always granted
	assign data_req = e_valid && (is_load || e_op == OP_SW);
	assign data_addr = e_result;
	assign data_we = e_valid && (e_op == OP_SW);
	assign data_wdata = e_store_data;

	// Memory/writeback register
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_en <= 1'b0;
			hlt <= 1'b0;
		end else begin
			wb_en <= e_valid && e_reg_write;
			// Everything older has left memory by now
			if (e_valid && e_halt)
				hlt <= 1'b1;
		end
		wb_rd <= e_rd;
		wb_data <= is_load ? mem_rdata : e_result;
	end

endmodule

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
	import cpu_pkg::*;
(
	input  logic  ext_en,
	input  word_t ext_addr,
	input  logic  ext_we,
	input  word_t ext_wdata,
	input  logic  data_req,
	input  word_t data_addr,
	input  logic  data_we,
	input  word_t data_wdata,
	input  logic  fetch_req,
	input  word_t fetch_addr,
	input  logic  fetch_we,
	input  word_t fetch_wdata,
	output logic  fetch_gnt,
	output word_t mem_addr,
	output logic  mem_we,
	output word_t mem_wdata
);
	// One-hot {ext, data, fetch}
	logic [2:0] gnt;

	always_comb begin
		gnt = 3'b000;
		if (ext_en)
			gnt = 3'b100;
		else if (data_req)
			gnt = 3'b010;
		else if (fetch_req)
			gnt = 3'b001;
	end

	assign fetch_gnt = gnt[0];

	// Idle port reads at the PC with no write
	always_comb begin
		mem_addr = fetch_addr;
		mem_we = 1'b0;
		mem_wdata = fetch_wdata;
		if (gnt[2]) begin
			mem_addr = ext_addr;
			mem_we = ext_we;
			mem_wdata = ext_wdata;
		end else if (gnt[1]) begin
			mem_addr = data_addr;
			mem_we = data_we;
			mem_wdata = data_wdata;
		end else if (gnt[0]) begin
			mem_we = fetch_we;
		end
	end

endmodule

//--- rtl/unified_memory.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module unified_memory (
	input  logic                      clk,
	input  logic [`CPU_WORD_BITS-1:0] addr,
	input  logic                      we,
	input  logic [`CPU_WORD_BITS-1:0] wdata,
	output logic [`CPU_WORD_BITS-1:0] rdata
);
	logic [`CPU_WORD_BITS-1:0] mem [1 << `CPU_MEM_ADDR_BITS];
	logic [`CPU_MEM_ADDR_BITS-1:0] word_addr;

	// Byte address in, bit 0 ignored
	assign word_addr = addr[`CPU_MEM_ADDR_BITS:1];

	always_ff @(posedge clk) begin
		if (we)
			mem[word_addr] <= wdata;
	end

	assign rdata = mem[word_addr];

endmodule

//--- rtl/cpu.sv
`timescale 1ns/1ps

module cpu
	import cpu_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  ext_en,
	input  logic  ext_we,
	input  word_t ext_addr,
	input  word_t ext_wdata,
	output word_t ext_rdata,
	output logic  hlt,
	output word_t pc
);
	// Fetch
	logic fetch_req, fetch_gnt, f_valid;
	word_t fetch_addr, pc_plus2;
	instr_t instr;
	// Decode and hazards
	logic stall, branch_taken, halt_seen, uses_rs, uses_rt;
	reg_idx_t rs, rt;
	word_t branch_target, reg_rs_data, reg_rt_data;
	logic d_valid, d_reg_write, d_halt, d_sets_flags;
	opcode_t d_op;
	reg_idx_t d_rd;
	word_t d_a, d_b, d_store_data;
	flags_t flags;
	// Execute/memory register
	logic e_valid, e_reg_write, e_halt;
	opcode_t e_op;
	reg_idx_t e_rd;
	word_t e_result, e_store_data;
	// Data port and writeback
	logic data_req, data_we, wb_en;
	word_t data_addr, data_wdata, wb_data;
	reg_idx_t wb_rd;
	// Shared memory port
	logic mem_we;
	word_t mem_addr, mem_wdata, mem_rdata;

	assign ext_rdata = mem_rdata;

	fetch_stage fetch_stage (.clk, .rst, .stall, .branch_taken, .branch_target, .halt_seen,
		.fetch_gnt, .mem_rdata, .fetch_req, .fetch_addr, .pc, .instr, .pc_plus2, .f_valid);

	decode_stage decode_stage (.clk, .rst, .stall, .instr, .pc_plus2, .f_valid, .flags,
		.reg_rs_data, .reg_rt_data, .rs, .rt, .uses_rs, .uses_rt, .branch_taken,
		.branch_target, .halt_seen, .d_valid, .d_op, .d_rd, .d_a, .d_b, .d_store_data,
		.d_reg_write, .d_halt);

	register_file register_file (.clk, .rst, .rs, .rt, .wb_en, .wb_rd, .wb_data,
		.rs_data(reg_rs_data), .rt_data(reg_rt_data));

	// Branch opcode in fetch/decode for the flag hazard
	detection_unit detection_unit (.rs, .rt, .uses_rs, .uses_rt, .f_valid,
		.f_is_branch(instr.branch_form.opcode == OP_B), .d_valid, .d_rd, .d_reg_write,
		.d_sets_flags, .e_valid, .e_rd, .e_reg_write, .stall);

	execute_stage execute_stage (.clk, .rst, .d_valid, .d_op, .d_rd, .d_a, .d_b,
		.d_store_data, .d_reg_write, .d_halt, .flags, .d_sets_flags, .e_valid, .e_op, .e_rd,
		.e_result, .e_store_data, .e_reg_write, .e_halt);

	memory_stage memory_stage (.clk, .rst, .e_valid, .e_op, .e_rd, .e_result, .e_store_data,
		.e_reg_write, .e_halt, .mem_rdata, .data_req, .data_addr, .data_we, .data_wdata,
		.wb_en, .wb_rd, .wb_data, .hlt);

	// Fetch never writes
	mem_arbiter mem_arbiter (.ext_en, .ext_addr, .ext_we, .ext_wdata, .data_req, .data_addr,
		.data_we, .data_wdata, .fetch_req, .fetch_addr, .fetch_we(1'b0), .fetch_wdata('0),
		.fetch_gnt, .mem_addr, .mem_we, .mem_wdata);

	unified_memory unified_memory (.clk, .addr(mem_addr), .we(mem_we), .wdata(mem_wdata),
		.rdata(mem_rdata));

endmodule

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
	import cpu_pkg::*;
();
	// Above all test budgets plus program loads and readback
	localparam int CYCLE_LIMIT = 20000;

	logic  clk;
	logic  rst;
	logic  ext_en;
	logic  ext_we;
	word_t ext_addr;
	word_t ext_wdata;
	word_t ext_rdata;
	logic  hlt;
	word_t pc;

	// Program image, data preloads and the words to compare
	logic [15:0] prog [$];
	logic [15:0] pre_addr [$];
	logic [15:0] pre_val [$];
	logic [15:0] checked [$];
	// Reference state with memory indexed by word
	logic [15:0] model_mem [4096];
	logic [15:0] model_reg [16];
	logic [31:0] rng_state;
	int cycles = 0;
	int errors;
	int passed;
	int failed;

	cpu DUT (.clk, .rst, .ext_en, .ext_we, .ext_addr, .ext_wdata, .ext_rdata, .hlt, .pc);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run-wide watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("ERROR: simulation ran past %0d cycles without finishing", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	// 32-bit xorshift with the low half used
	function automatic logic [15:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state[15:0];
	endfunction

	function automatic logic [15:0] r_word(input opcode_t op, input logic [3:0] a, b, c);
		return {op, a, b, c};
	endfunction

	function automatic logic [15:0] sext4(input logic [3:0] v);
		return {{12{v[3]}}, v};
	endfunction

	// {n, z, v} after ADD or SUB
	function automatic logic [2:0] flags_after(input logic is_sub, input logic [15:0] a, b);
		logic [15:0] r;
		int wide;
		r = is_sub ? a - b : a + b;
		// True signed result, V when it leaves the 16-bit range
		if (is_sub)
			wide = int'($signed(a)) - int'($signed(b));
		else
			wide = int'($signed(a)) + int'($signed(b));
		return {r[15], r == 16'h0000, (wide > 32767) || (wide < -32768)};
	endfunction

	function automatic logic cond_holds(input logic [2:0] cond, input logic [2:0] nzv);
		logic n;
		logic z;
		logic v;
		{n, z, v} = nzv;
		case (cond)
			COND_NE: return !z;
			COND_EQ: return z;
			COND_GT: return !z && !n;
			COND_LT: return n;
			COND_GE: return !n;
			COND_LE: return n || z;
			COND_OV: return v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic clear_model();
		prog.delete();
		pre_addr.delete();
		pre_val.delete();
		checked.delete();
		foreach (model_reg[i])
			model_reg[i] = '0;
	endtask

	task automatic emit(input logic [15:0] w);
		prog.push_back(w);
	endtask

	task automatic preload(input logic [15:0] addr, input logic [15:0] val);
		pre_addr.push_back(addr);
		pre_val.push_back(val);
		model_mem[addr[12:1]] = val;
	endtask

	task automatic expect_word(input logic [15:0] addr, input logic [15:0] val);
		model_mem[addr[12:1]] = val;
		checked.push_back(addr);
	endtask

	// Emitters that also step the reference registers
	task automatic llb(input logic [3:0] rd, input logic [7:0] imm);
		emit({OP_LLB, rd, imm});
		if (rd != 0)
			model_reg[rd] = {8'h00, imm};
	endtask

	task automatic alu(input opcode_t op, input logic [3:0] rd, rs, rt);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		a = model_reg[rs];
		b = model_reg[rt];
		case (op)
			OP_ADD: r = a + b;
			OP_SUB: r = a - b;
			OP_AND: r = a & b;
			default: r = a ^ b;
		endcase
		emit(r_word(op, rd, rs, rt));
		if (rd != 0)
			model_reg[rd] = r;
	endtask

	task automatic add_imm(input logic [3:0] rd, rs, imm);
		emit(r_word(OP_ADDI, rd, rs, imm));
		if (rd != 0)
			model_reg[rd] = model_reg[rs] + sext4(imm);
	endtask

	task automatic load(input logic [3:0] rd, rs, off);
		logic [15:0] addr;
		addr = model_reg[rs] + (sext4(off) << 1);
		emit(r_word(OP_LW, rd, rs, off));
		if (rd != 0)
			model_reg[rd] = model_mem[addr[12:1]];
	endtask

	// Data register sits in the rd field
	task automatic store(input logic [3:0] rd, rs, off);
		logic [15:0] addr;
		addr = model_reg[rs] + (sext4(off) << 1);
		emit(r_word(OP_SW, rd, rs, off));
		expect_word(addr, model_reg[rd]);
	endtask

	// 0x80 doubled three times gives byte 0x400
	task automatic build_data_base(input logic [3:0] rd);
		llb(rd, 8'h80);
		repeat (3)
			alu(OP_ADD, rd, rd, rd);
	endtask

	task automatic write_word(input logic [15:0] addr, input logic [15:0] data);
		ext_en = 1'b1;
		ext_we = 1'b1;
		ext_addr = addr;
		ext_wdata = data;
		@(negedge clk);
	endtask

	// Reset for 4 cycles then code and data through the ext port
	task automatic load_program();
		@(negedge clk);
		rst = 1'b1;
		ext_en = 1'b0;
		repeat (4) @(negedge clk);
		for (int i = 0; i < prog.size(); i++)
			write_word(i * 2, prog[i]);
		foreach (pre_addr[i])
			write_word(pre_addr[i], pre_val[i]);
		ext_en = 1'b0;
		ext_we = 1'b0;
		rst = 1'b0;
	endtask

	task automatic wait_for_halt(input string name, input int budget);
		int n;
		n = 0;
		while (!hlt && n < budget) begin
			@(negedge clk);
			n++;
		end
		if (!hlt) begin
			$display("ERROR: %s did not reach HLT within %0d cycles", name, budget);
			errors++;
		end
	endtask

	// Budget is five cycles per executed instruction
	task automatic run_program(input string name, input int dyn);
		load_program();
		wait_for_halt(name, 5 * dyn);
	endtask

	// Readback only once halted
	task automatic check_memory(input string name);
		logic [15:0] got;
		logic [15:0] want;
		if (!hlt)
			return;
		foreach (checked[i]) begin
			want = model_mem[checked[i][12:1]];
			@(negedge clk);
			ext_en = 1'b1;
			ext_we = 1'b0;
			ext_addr = checked[i];
			@(posedge clk);
			got = ext_rdata;
			if (got !== want) begin
				$display("CHECK FAILED %s: word %h expected %h actual %h",
					name, checked[i], want, got);
				errors++;
			end
		end
		@(negedge clk);
		ext_en = 1'b0;
	endtask

	task automatic report(input string name, input int errors_before);
		if (errors == errors_before) begin
			passed++;
			$display("PASS %s", name);
		end else begin
			failed++;
			$display("FAIL %s (%0d errors)", name, errors - errors_before);
		end
	endtask

	task automatic alu_dependencies();
		int errors_before;
		logic [15:0] r;
		errors_before = errors;
		clear_model();
		build_data_base(4'd13);
		llb(4'd12, 8'd16);
		for (int k = 0; k < 4; k++) begin
			r = next_random();
			llb(4'd1, r[7:0]);
			llb(4'd2, r[15:8]);
			// Each op reads the result just produced
			alu(OP_ADD, 4'd3, 4'd1, 4'd2);
			alu(OP_SUB, 4'd4, 4'd1, 4'd3);
			alu(OP_AND, 4'd5, 4'd4, 4'd3);
			alu(OP_XOR, 4'd6, 4'd5, 4'd2);
			r = next_random();
			add_imm(4'd7, 4'd6, r[3:0]);
			alu(OP_SUB, 4'd8, 4'd2, 4'd7);
			for (int s = 3; s <= 8; s++)
				store(s, 4'd13, s - 3);
			alu(OP_ADD, 4'd13, 4'd13, 4'd12);
		end
		// r0 ignores the write
		alu(OP_ADD, 4'd0, 4'd1, 4'd2);
		alu(OP_ADD, 4'd9, 4'd0, 4'd1);
		store(4'd0, 4'd13, 4'd0);
		store(4'd9, 4'd13, 4'd1);
		emit(r_word(OP_HLT, 0, 0, 0));
		run_program("alu_dependencies", prog.size());
		check_memory("alu_dependencies");
		report("alu_dependencies", errors_before);
	endtask

	task automatic load_store_sharing();
		int errors_before;
		errors_before = errors;
		clear_model();
		for (int i = 0; i < 8; i++)
			preload(16'h0400 + i * 2, next_random());
		build_data_base(4'd13);
		llb(4'd11, 8'd16);
		alu(OP_ADD, 4'd12, 4'd13, 4'd11);
		for (int i = 0; i < 4; i++) begin
			load(4'd1, 4'd13, i);
			// Negative offsets from base+16
			load(4'd2, 4'd12, -(i + 1));
			// Load-use right away
			alu(OP_ADD, 4'd3, 4'd1, 4'd2);
			store(4'd3, 4'd12, i);
			store(4'd1, 4'd12, i + 4);
		end
		load(4'd4, 4'd12, 4'd0);
		store(4'd4, 4'd13, 4'hF);
		emit(r_word(OP_HLT, 0, 0, 0));
		run_program("load_store_sharing", prog.size());
		check_memory("load_store_sharing");
		report("load_store_sharing", errors_before);
	endtask

	task automatic branch_conditions();
		// Scenarios 9-3, 5-5, 3-9 and 0x7FFF+1
		int sc_ra [4] = '{5, 7, 6, 9};
		int sc_rb [4] = '{6, 7, 5, 10};
		int sc_sub [4] = '{1, 1, 1, 0};
		// Scenario that holds and one that fails per condition (AL always holds)
		int true_case [8] = '{0, 1, 0, 2, 1, 2, 3, 1};
		int false_case [8] = '{1, 0, 2, 0, 2, 0, 0, 2};
		int errors_before;
		int sc;
		int taken;
		logic [2:0] cond;
		logic [2:0] nzv;
		logic hold;
		errors_before = errors;
		taken = 0;
		clear_model();
		preload(16'h0410, 16'h7FFF);
		build_data_base(4'd13);
		llb(4'd11, 8'd16);
		alu(OP_ADD, 4'd12, 4'd13, 4'd11);
		load(4'd9, 4'd12, 4'd0);
		llb(4'd10, 8'd1);
		llb(4'd5, 8'd9);
		llb(4'd6, 8'd3);
		llb(4'd7, 8'd5);
		for (int j = 0; j < 16; j++) begin
			cond = j / 2;
			sc = (j % 2) ? false_case[j / 2] : true_case[j / 2];
			nzv = flags_after(sc_sub[sc], model_reg[sc_ra[sc]], model_reg[sc_rb[sc]]);
			hold = cond_holds(cond, nzv);
			// Taken branches skip the ADDI
			if (hold)
				taken++;
			llb(4'd4, 8'd0);
			if (sc_sub[sc])
				emit(r_word(OP_SUB, 4'd3, sc_ra[sc], sc_rb[sc]));
			else
				emit(r_word(OP_ADD, 4'd3, sc_ra[sc], sc_rb[sc]));
			// Branch right behind the setter skips one word
			emit({OP_B, cond, 9'd1});
			emit(r_word(OP_ADDI, 4'd4, 4'd4, 4'd1));
			emit(r_word(OP_SW, 4'd4, 4'd13, j - 8));
			expect_word(16'h0400 + (j - 8) * 2, hold ? 16'd0 : 16'd1);
		end
		emit(r_word(OP_HLT, 0, 0, 0));
		run_program("branch_conditions", prog.size() - taken);
		check_memory("branch_conditions");
		report("branch_conditions", errors_before);
	endtask

	task automatic summing_loop();
		int errors_before;
		logic [15:0] w;
		logic [15:0] sum;
		errors_before = errors;
		clear_model();
		sum = '0;
		for (int i = 0; i < 8; i++) begin
			w = next_random();
			preload(16'h0400 + i * 2, w);
			sum += w;
		end
		build_data_base(4'd13);
		llb(4'd1, 8'd0);
		llb(4'd2, 8'd8);
		alu(OP_ADD, 4'd3, 4'd13, 4'd0);
		// Five-word body where the counter drives Z
		emit(r_word(OP_LW, 4'd4, 4'd3, 4'd0));
		emit(r_word(OP_ADD, 4'd1, 4'd1, 4'd4));
		emit(r_word(OP_ADDI, 4'd3, 4'd3, 4'd2));
		emit(r_word(OP_ADDI, 4'd2, 4'd2, 4'hF));
		emit({OP_B, COND_NE, 9'h1FB});
		emit(r_word(OP_SW, 4'd1, 4'd13, 4'hF));
		emit(r_word(OP_HLT, 0, 0, 0));
		expect_word(16'h03FE, sum);
		run_program("summing_loop", 7 + 8 * 5 + 2);
		check_memory("summing_loop");
		report("summing_loop", errors_before);
	endtask

	task automatic halt_behavior();
		int errors_before;
		logic [15:0] held_pc;
		errors_before = errors;
		clear_model();
		preload(16'h00F0, next_random());
		checked.push_back(16'h00F0);
		llb(4'd2, 8'hF0);
		llb(4'd1, 8'h55);
		alu(OP_ADD, 4'd3, 4'd1, 4'd1);
		store(4'd3, 4'd2, 4'd1);
		emit(r_word(OP_HLT, 0, 0, 0));
		// Never reaches memory
		emit(r_word(OP_SW, 4'd1, 4'd2, 4'd0));
		run_program("halt_behavior", 5);
		if (hlt) begin
			held_pc = pc;
			repeat (10) begin
				@(negedge clk);
				if (pc !== held_pc) begin
					$display("CHECK FAILED halt_behavior: pc expected %h actual %h", held_pc, pc);
					errors++;
				end
				if (hlt !== 1'b1) begin
					$display("CHECK FAILED halt_behavior: hlt expected 1 actual %b", hlt);
					errors++;
				end
			end
		end
		check_memory("halt_behavior");
		report("halt_behavior", errors_before);
	endtask

	initial begin
		rst = 1'b1;
		ext_en = 1'b0;
		ext_we = 1'b0;
		ext_addr = '0;
		ext_wdata = '0;
		rng_state = 32'd41;
		errors = 0;
		passed = 0;
		failed = 0;
		alu_dependencies();
		load_store_sharing();
		branch_conditions();
		summing_loop();
		halt_behavior();
		$display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/detection_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/mem_arbiter.sv
rtl/unified_memory.sv
rtl/cpu.sv
testbench/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/fetch_stage.sv
      - rtl/decode_stage.sv
      - rtl/register_file.sv
      - rtl/detection_unit.sv
      - rtl/execute_stage.sv
      - rtl/memory_stage.sv
      - rtl/mem_arbiter.sv
      - rtl/unified_memory.sv
      - rtl/cpu.sv
  - target: test
    files:
      - testbench/cpu_tb.sv
